// File: common/biu_arb_consts.svh
`ifndef BIU_ARB_CONSTS_SVH
`define BIU_ARB_CONSTS_SVH

// Bus widths
`define BIU_ADDR_W 40
`define BIU_DATA_W 128
`define BIU_STRB_W 16
`define BIU_ID_W 4

// Address bits from here upward select the peripheral region
`define BIU_REGION_LSB 27

// Write-order queue
`define BIU_WQ_DEPTH 8
`define BIU_WQ_PTR_W 3

`endif

// File: common/biu_arb_pkg.sv
`include "biu_arb_consts.svh"

package biu_arb_pkg;

  // Id ranges per source
  // ifu owns ids 0 and 1, lsu owns ids 2 to 15
  // so the read router only looks at id bits above bit 0

  // ==============================
  // Address channels
  // ==============================

  // Read address payload
  typedef struct packed {
    logic [`BIU_ADDR_W-1:0] addr;
    logic [`BIU_ID_W-1:0]   id;
    logic [2:0]             size;
    logic [1:0]             len;
    logic [1:0]             burst;
    logic [2:0]             prot;
  } ar_req_t;

  // Write address payload, same layout as reads
  typedef struct packed {
    logic [`BIU_ADDR_W-1:0] addr;
    logic [`BIU_ID_W-1:0]   id;
    logic [2:0]             size;
    logic [1:0]             len;
    logic [1:0]             burst;
    logic [2:0]             prot;
  } aw_req_t;

  // ==============================
  // Data channels
  // ==============================

  typedef struct packed {
    logic [`BIU_DATA_W-1:0] data;
    logic [`BIU_STRB_W-1:0] strb;
    logic                   last;
  } w_beat_t;

  typedef struct packed {
    logic [`BIU_DATA_W-1:0] data;
    logic [`BIU_ID_W-1:0]   id;
    logic [1:0]             resp;
    logic                   last;
  } r_beat_t;

endpackage

// File: hw/addr_arbiter.sv
`include "biu_arb_consts.svh"

module addr_arbiter #(
  parameter type req_t = biu_arb_pkg::ar_req_t
) (
  input  logic                   arb_clk,
  input  logic                   cpurst_b,
  input  logic                   hi_valid,
  input  req_t                   hi_req,
  input  logic                   lo_valid,
  input  req_t                   lo_req,
  input  logic [`BIU_ADDR_W-1:0] apb_base,
  input  logic                   apb_ready,
  input  logic                   axi_ready,
  output logic                   hi_ready,
  output logic                   lo_ready,
  output logic                   apb_valid,
  output logic                   axi_valid,
  output req_t                   out_req,
  output logic                   hi_grant
);

  logic any_valid;
  logic apb_hit;
  logic side_ready;

  // ==============================
  // Fixed priority select
  // ==============================

  // High source wins whenever it asks
  assign hi_grant  = hi_valid;
  assign any_valid = hi_valid | lo_valid;
  assign out_req   = hi_valid ? hi_req : lo_req;

  // ==============================
  // Region decode
  // ==============================

  // Upper address bits against the programmed peripheral base
  assign apb_hit = out_req.addr[`BIU_ADDR_W-1:`BIU_REGION_LSB]
                   == apb_base[`BIU_ADDR_W-1:`BIU_REGION_LSB];

  assign apb_valid = any_valid & apb_hit;
  assign axi_valid = any_valid & ~apb_hit;

  // Ready of the decoded side goes back to the winner
  assign side_ready = apb_hit ? apb_ready : axi_ready;
  assign hi_ready   = side_ready;
  // Low source only sees ready while the high one is quiet
  assign lo_ready   = side_ready & ~hi_valid;

  // Region base stays put while a request is offered, so a waiting request keeps its side
  a_one_side: assert property (
    @(posedge arb_clk) disable iff (!cpurst_b)
    any_valid |-> $stable(apb_base)
  ) else $error("addr_arbiter: apb base changed under a pending request");

endmodule

// File: hw/rdata_router.sv
`include "biu_arb_consts.svh"

module rdata_router (
  input  logic                  axi_r_valid,
  input  biu_arb_pkg::r_beat_t  axi_r,
  input  logic                  apb_r_valid,
  input  biu_arb_pkg::r_beat_t  apb_r,
  output logic                  ifu_r_valid,
  output biu_arb_pkg::r_beat_t  ifu_r,
  output logic                  lsu_r_valid,
  output biu_arb_pkg::r_beat_t  lsu_r,
  output logic                  apb_r_ready
);

  logic                 id_is_ifu;
  logic                 axi_lsu_valid;
  biu_arb_pkg::r_beat_t apb_beat;

  // ==============================
  // Axi read data
  // ==============================

  // ifu ids are 0 and 1
  assign id_is_ifu = axi_r.id[`BIU_ID_W-1:1] == '0;

  assign ifu_r_valid   = axi_r_valid & id_is_ifu;
  assign ifu_r         = axi_r;
  assign axi_lsu_valid = axi_r_valid & ~id_is_ifu;

  // ==============================
  // Apb read data
  // ==============================

  // Apb returns single beats
  always_comb
  begin
    apb_beat      = apb_r;
    apb_beat.last = 1'b1;
  end

  // Axi lsu data has the lsu port first
  assign lsu_r_valid = axi_lsu_valid | apb_r_valid;
  assign lsu_r       = axi_lsu_valid ? axi_r : apb_beat;

  // Apb holds its beat while axi owns the lsu port
  assign apb_r_ready = ~axi_lsu_valid;

endmodule

// File: hw/write_order/write_order_queue.sv
`include "biu_arb_consts.svh"

module write_order_queue (
  input  logic                  arb_clk,
  input  logic                  cpurst_b,
  input  logic                  aw_apb_valid_in,
  input  logic                  aw_axi_valid_in,
  input  biu_arb_pkg::aw_req_t  aw_req,
  input  logic                  aw_hi_grant,
  input  logic                  apb_aw_ready,
  input  logic                  axi_aw_ready,
  input  logic                  vb_w_valid,
  input  biu_arb_pkg::w_beat_t  vb_w,
  input  logic                  stb_w_valid,
  input  biu_arb_pkg::w_beat_t  stb_w,
  input  logic                  apb_w_ready,
  input  logic                  axi_w_ready,
  output logic                  apb_aw_valid,
  output logic                  axi_aw_valid,
  output biu_arb_pkg::aw_req_t  apb_aw,
  output biu_arb_pkg::aw_req_t  axi_aw,
  output logic                  aw_apb_ready_out,
  output logic                  aw_axi_ready_out,
  output logic                  apb_w_valid,
  output logic                  axi_w_valid,
  output biu_arb_pkg::w_beat_t  w_out,
  output logic                  vb_w_ready,
  output logic                  stb_w_ready
);

  localparam logic [`BIU_WQ_PTR_W:0] PTR_ONE = 1;

  // Extra top bit on each pointer tells full from empty
  logic [`BIU_WQ_PTR_W:0]    wr_ptr;
  logic [`BIU_WQ_PTR_W:0]    rd_ptr;
  logic [`BIU_WQ_DEPTH-1:0]  src_vb_q;
  logic [`BIU_WQ_DEPTH-1:0]  dst_apb_q;
  logic full;
  logic empty;
  logic push;
  logic pop;
  logic head_vb;
  logic head_apb;
  logic beat_valid;
  logic beat_ready;

  assign empty = wr_ptr == rd_ptr;
  assign full  = (wr_ptr[`BIU_WQ_PTR_W] != rd_ptr[`BIU_WQ_PTR_W])
               & (wr_ptr[`BIU_WQ_PTR_W-1:0] == rd_ptr[`BIU_WQ_PTR_W-1:0]);

  // ==============================
  // Write address gating
  // ==============================

  // Full queue stalls both sides
  assign apb_aw_valid     = aw_apb_valid_in & ~full;
  assign axi_aw_valid     = aw_axi_valid_in & ~full;
  assign aw_apb_ready_out = apb_aw_ready & ~full;
  assign aw_axi_ready_out = axi_aw_ready & ~full;
  assign apb_aw           = aw_req;
  assign axi_aw           = aw_req;

  assign push = (apb_aw_valid & apb_aw_ready) | (axi_aw_valid & axi_aw_ready);

  // Entry flags: source was vb, destination is apb
  always_ff @(posedge arb_clk)
  begin
    if (push)
    begin
      src_vb_q[wr_ptr[`BIU_WQ_PTR_W-1:0]]  <= aw_hi_grant;
      dst_apb_q[wr_ptr[`BIU_WQ_PTR_W-1:0]] <= aw_apb_valid_in;
    end
  end

  // ==============================
  // Write beat steering
  // ==============================

  assign head_vb  = src_vb_q[rd_ptr[`BIU_WQ_PTR_W-1:0]];
  assign head_apb = dst_apb_q[rd_ptr[`BIU_WQ_PTR_W-1:0]];

  assign beat_valid  = ~empty & (head_vb ? vb_w_valid : stb_w_valid);
  assign w_out       = head_vb ? vb_w : stb_w;
  assign apb_w_valid = beat_valid & head_apb;
  assign axi_w_valid = beat_valid & ~head_apb;

  // Only the head entry's source is let through
  assign beat_ready  = head_apb ? apb_w_ready : axi_w_ready;
  assign vb_w_ready  = ~empty & beat_ready & head_vb;
  assign stb_w_ready = ~empty & beat_ready & ~head_vb;

  assign pop = beat_valid & beat_ready & w_out.last;

  always_ff @(posedge arb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + PTR_ONE;
      if (pop)
        rd_ptr <= rd_ptr + PTR_ONE;
    end
  end

  // Read pointer holds while nothing is queued
  a_no_pop_empty: assert property (
    @(posedge arb_clk) disable iff (!cpurst_b)
    empty |=> rd_ptr == $past(rd_ptr)
  ) else $error("write_order_queue: entry retired from an empty queue");

  // Write pointer holds while every entry is taken
  a_no_push_full: assert property (
    @(posedge arb_clk) disable iff (!cpurst_b)
    full |=> wr_ptr == $past(wr_ptr)
  ) else $error("write_order_queue: write address accepted into a full queue");

endmodule

// File: hw/biu_req_arb.sv
`include "biu_arb_consts.svh"

module biu_req_arb (
  input  logic                   arb_clk,
  input  logic                   cpurst_b,
  input  logic [`BIU_ADDR_W-1:0] apb_base,
  // Upstream read requests
  input  logic                   lsu_ar_valid,
  input  biu_arb_pkg::ar_req_t   lsu_ar,
  output logic                   lsu_ar_ready,
  input  logic                   ifu_ar_valid,
  input  biu_arb_pkg::ar_req_t   ifu_ar,
  output logic                   ifu_ar_ready,
  // Upstream write requests
  input  logic                   vb_aw_valid,
  input  biu_arb_pkg::aw_req_t   vb_aw,
  output logic                   vb_aw_ready,
  input  logic                   stb_aw_valid,
  input  biu_arb_pkg::aw_req_t   stb_aw,
  output logic                   stb_aw_ready,
  input  logic                   vb_w_valid,
  input  biu_arb_pkg::w_beat_t   vb_w,
  output logic                   vb_w_ready,
  input  logic                   stb_w_valid,
  input  biu_arb_pkg::w_beat_t   stb_w,
  output logic                   stb_w_ready,
  // Read data to units
  output logic                   ifu_r_valid,
  output biu_arb_pkg::r_beat_t   ifu_r,
  output logic                   lsu_r_valid,
  output biu_arb_pkg::r_beat_t   lsu_r,
  // Axi side
  output logic                   axi_ar_valid,
  output biu_arb_pkg::ar_req_t   axi_ar,
  input  logic                   axi_ar_ready,
  output logic                   axi_aw_valid,
  output biu_arb_pkg::aw_req_t   axi_aw,
  input  logic                   axi_aw_ready,
  output logic                   axi_w_valid,
  output biu_arb_pkg::w_beat_t   axi_w,
  input  logic                   axi_w_ready,
  input  logic                   axi_r_valid,
  input  biu_arb_pkg::r_beat_t   axi_r,
  // Apb side
  output logic                   apb_ar_valid,
  output biu_arb_pkg::ar_req_t   apb_ar,
  input  logic                   apb_ar_ready,
  output logic                   apb_aw_valid,
  output biu_arb_pkg::aw_req_t   apb_aw,
  input  logic                   apb_aw_ready,
  output logic                   apb_w_valid,
  output biu_arb_pkg::w_beat_t   apb_w,
  input  logic                   apb_w_ready,
  input  logic                   apb_r_valid,
  input  biu_arb_pkg::r_beat_t   apb_r,
  output logic                   apb_r_ready
);

  biu_arb_pkg::ar_req_t ar_win;
  biu_arb_pkg::aw_req_t aw_win;
  biu_arb_pkg::w_beat_t w_win;
  logic aw_apb_valid;
  logic aw_axi_valid;
  logic aw_apb_ready;
  logic aw_axi_ready;
  logic aw_hi_grant;

  // One winner payload feeds both sides
  assign axi_ar = ar_win;
  assign apb_ar = ar_win;
  assign axi_w  = w_win;
  assign apb_w  = w_win;

  // ==============================
  // Read address, lsu over ifu
  // ==============================
  addr_arbiter #(.req_t(biu_arb_pkg::ar_req_t)) u_ar_arb (
    .arb_clk   (arb_clk),
    .cpurst_b  (cpurst_b),
    .hi_valid  (lsu_ar_valid),
    .hi_req    (lsu_ar),
    .lo_valid  (ifu_ar_valid),
    .lo_req    (ifu_ar),
    .apb_base  (apb_base),
    .apb_ready (apb_ar_ready),
    .axi_ready (axi_ar_ready),
    .hi_ready  (lsu_ar_ready),
    .lo_ready  (ifu_ar_ready),
    .apb_valid (apb_ar_valid),
    .axi_valid (axi_ar_valid),
    .out_req   (ar_win),
    .hi_grant  ()
  );

  // ==============================
  // Write address, vb over stb
  // ==============================
  addr_arbiter #(.req_t(biu_arb_pkg::aw_req_t)) u_aw_arb (
    .arb_clk   (arb_clk),
    .cpurst_b  (cpurst_b),
    .hi_valid  (vb_aw_valid),
    .hi_req    (vb_aw),
    .lo_valid  (stb_aw_valid),
    .lo_req    (stb_aw),
    .apb_base  (apb_base),
    .apb_ready (aw_apb_ready),
    .axi_ready (aw_axi_ready),
    .hi_ready  (vb_aw_ready),
    .lo_ready  (stb_aw_ready),
    .apb_valid (aw_apb_valid),
    .axi_valid (aw_axi_valid),
    .out_req   (aw_win),
    .hi_grant  (aw_hi_grant)
  );

  rdata_router u_rdata_router (
    .axi_r_valid (axi_r_valid),
    .axi_r       (axi_r),
    .apb_r_valid (apb_r_valid),
    .apb_r       (apb_r),
    .ifu_r_valid (ifu_r_valid),
    .ifu_r       (ifu_r),
    .lsu_r_valid (lsu_r_valid),
    .lsu_r       (lsu_r),
    .apb_r_ready (apb_r_ready)
  );

  // Address order decides beat order
  write_order_queue u_write_order_queue (
    .arb_clk          (arb_clk),
    .cpurst_b         (cpurst_b),
    .aw_apb_valid_in  (aw_apb_valid),
    .aw_axi_valid_in  (aw_axi_valid),
    .aw_req           (aw_win),
    .aw_hi_grant      (aw_hi_grant),
    .apb_aw_ready     (apb_aw_ready),
    .axi_aw_ready     (axi_aw_ready),
    .vb_w_valid       (vb_w_valid),
    .vb_w             (vb_w),
    .stb_w_valid      (stb_w_valid),
    .stb_w            (stb_w),
    .apb_w_ready      (apb_w_ready),
    .axi_w_ready      (axi_w_ready),
    .apb_aw_valid     (apb_aw_valid),
    .axi_aw_valid     (axi_aw_valid),
    .apb_aw           (apb_aw),
    .axi_aw           (axi_aw),
    .aw_apb_ready_out (aw_apb_ready),
    .aw_axi_ready_out (aw_axi_ready),
    .apb_w_valid      (apb_w_valid),
    .axi_w_valid      (axi_w_valid),
    .w_out            (w_win),
    .vb_w_ready       (vb_w_ready),
    .stb_w_ready      (stb_w_ready)
  );

endmodule

// File: verification/biu_arb_checks.svh
`ifndef BIU_ARB_CHECKS_SVH
`define BIU_ARB_CHECKS_SVH

  // ==============================
  // Compare tasks
  // ==============================

  // Valid and ready bits of one channel group
  task automatic check_ctrl(input logic [3:0] got, input logic [3:0] exp,
                            input string what);
    if (got !== exp)
      stop_on_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_ar(input biu_arb_pkg::ar_req_t got,
                          input biu_arb_pkg::ar_req_t exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("%s got addr %h id %h expected addr %h id %h (%h vs %h)",
                              what, got.addr, got.id, exp.addr, exp.id, got, exp));
  endtask

  task automatic check_aw(input biu_arb_pkg::aw_req_t got,
                          input biu_arb_pkg::aw_req_t exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("%s got addr %h id %h expected addr %h id %h (%h vs %h)",
                              what, got.addr, got.id, exp.addr, exp.id, got, exp));
  endtask

  // Whole beat, strobes and last included
  task automatic check_w(input biu_arb_pkg::w_beat_t got,
                         input biu_arb_pkg::w_beat_t exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("%s got strb %h last %b data %h expected strb %h last %b data %h",
                              what, got.strb, got.last, got.data,
                              exp.strb, exp.last, exp.data));
  endtask

  task automatic check_r(input biu_arb_pkg::r_beat_t got,
                         input biu_arb_pkg::r_beat_t exp, input string what);
    if (got !== exp)
      stop_on_error($sformatf("%s got id %h last %b data %h expected id %h last %b data %h",
                              what, got.id, got.last, got.data,
                              exp.id, exp.last, exp.data));
  endtask

`endif

// File: verification/biu_req_arb_tb.sv
`include "biu_arb_consts.svh"

module biu_req_arb_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD      = 40;
  localparam int DRIVE_DLY       = 2;
  localparam int SAMPLE_DLY      = CLK_PERIOD - 2;
  localparam int RAND_TESTS      = 10;
  localparam int CYCLES_PER_TEST = 30;
  localparam int N_TESTS         = RAND_TESTS + 1;
  localparam int TIMEOUT_NS      = (N_TESTS * 40 + 200) * CLK_PERIOD;
  localparam int REQ_TAIL_W      = $bits(biu_arb_pkg::ar_req_t) - `BIU_ADDR_W;

  // Expected routing of one arbitrated channel
  typedef struct packed {
    logic apb_valid;
    logic axi_valid;
    logic hi_ready;
    logic lo_ready;
    logic hi_win;
  } route_t;

  logic arb_clk;
  logic cpurst_b;
  logic [`BIU_ADDR_W-1:0] apb_base;
  logic lsu_ar_valid, lsu_ar_ready, ifu_ar_valid, ifu_ar_ready;
  logic vb_aw_valid, vb_aw_ready, stb_aw_valid, stb_aw_ready;
  logic vb_w_valid, vb_w_ready, stb_w_valid, stb_w_ready;
  logic ifu_r_valid, lsu_r_valid, axi_r_valid, apb_r_valid, apb_r_ready;
  logic axi_ar_valid, axi_ar_ready, axi_aw_valid, axi_aw_ready, axi_w_valid, axi_w_ready;
  logic apb_ar_valid, apb_ar_ready, apb_aw_valid, apb_aw_ready, apb_w_valid, apb_w_ready;
  biu_arb_pkg::ar_req_t lsu_ar, ifu_ar, axi_ar, apb_ar;
  biu_arb_pkg::aw_req_t vb_aw, stb_aw, axi_aw, apb_aw;
  biu_arb_pkg::w_beat_t vb_w, stb_w, axi_w, apb_w;
  biu_arb_pkg::r_beat_t ifu_r, lsu_r, axi_r, apb_r;

  integer seed = 32'h8f0145ac;
  // Expected write order, each entry {source was vb, destination is apb}
  logic [1:0] exp_wq[$];

  biu_req_arb u_dut (.*);

  // First mismatch ends the run
  task automatic stop_on_error(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1, "Stopping at first mismatch");
  endtask

  `include "biu_arb_checks.svh"

  // ==============================
  // Reference model
  // ==============================

  // Fixed priority, then region decode of the winner
  function automatic route_t ref_route(input logic hi_valid, input logic lo_valid,
                                       input logic [`BIU_ADDR_W-1:0] hi_addr,
                                       input logic [`BIU_ADDR_W-1:0] lo_addr,
                                       input logic apb_rdy, input logic axi_rdy);
    route_t r;
    logic [`BIU_ADDR_W-1:0] addr;
    logic hit;
    addr       = hi_valid ? hi_addr : lo_addr;
    hit        = addr[`BIU_ADDR_W-1:`BIU_REGION_LSB]
                 == apb_base[`BIU_ADDR_W-1:`BIU_REGION_LSB];
    r.hi_win    = hi_valid;
    r.apb_valid = (hi_valid | lo_valid) & hit;
    r.axi_valid = (hi_valid | lo_valid) & ~hit;
    r.hi_ready  = hit ? apb_rdy : axi_rdy;
    r.lo_ready  = r.hi_ready & ~hi_valid;
    return r;
  endfunction

  task automatic compare_cycle();
    route_t ar_exp;
    route_t aw_exp;
    logic full;
    logic [1:0] head;
    logic src_valid;
    logic side_rdy;
    logic ifu_hit;
    logic axi_lsu;
    biu_arb_pkg::w_beat_t w_exp;
    biu_arb_pkg::r_beat_t r_exp;
    ar_exp = ref_route(lsu_ar_valid, ifu_ar_valid, lsu_ar.addr, ifu_ar.addr,
                       apb_ar_ready, axi_ar_ready);
    check_ctrl({apb_ar_valid, axi_ar_valid, lsu_ar_ready, ifu_ar_ready},
               {ar_exp.apb_valid, ar_exp.axi_valid, ar_exp.hi_ready, ar_exp.lo_ready},
               "read address handshake");
    if (lsu_ar_valid | ifu_ar_valid)
    begin
      check_ar(apb_ar, ar_exp.hi_win ? lsu_ar : ifu_ar, "apb read address");
      check_ar(axi_ar, ar_exp.hi_win ? lsu_ar : ifu_ar, "axi read address");
    end
    // Full queue holds both write address sides
    full   = exp_wq.size() == `BIU_WQ_DEPTH;
    aw_exp = ref_route(vb_aw_valid, stb_aw_valid, vb_aw.addr, stb_aw.addr,
                       apb_aw_ready & ~full, axi_aw_ready & ~full);
    check_ctrl({apb_aw_valid, axi_aw_valid, vb_aw_ready, stb_aw_ready},
               {aw_exp.apb_valid & ~full, aw_exp.axi_valid & ~full,
                aw_exp.hi_ready, aw_exp.lo_ready}, "write address handshake");
    if ((vb_aw_valid | stb_aw_valid) & ~full)
    begin
      check_aw(apb_aw, aw_exp.hi_win ? vb_aw : stb_aw, "apb write address");
      check_aw(axi_aw, aw_exp.hi_win ? vb_aw : stb_aw, "axi write address");
    end
    // Oldest address picks beat source and side
    head      = (exp_wq.size() > 0) ? exp_wq[0] : 2'b00;
    src_valid = (exp_wq.size() > 0) & (head[1] ? vb_w_valid : stb_w_valid);
    side_rdy  = (exp_wq.size() > 0) & (head[0] ? apb_w_ready : axi_w_ready);
    w_exp     = head[1] ? vb_w : stb_w;
    check_ctrl({apb_w_valid, axi_w_valid, vb_w_ready, stb_w_ready},
               {src_valid & head[0], src_valid & ~head[0],
                side_rdy & head[1], side_rdy & ~head[1]}, "write beat handshake");
    if (src_valid)
      check_w(head[0] ? apb_w : axi_w, w_exp, "write beat");
    // Ids 0 and 1 belong to ifu
    ifu_hit    = axi_r_valid & (axi_r.id < 4'd2);
    axi_lsu    = axi_r_valid & ~ifu_hit;
    r_exp      = apb_r;
    r_exp.last = 1'b1;
    check_ctrl({ifu_r_valid, lsu_r_valid, apb_r_ready, 1'b0},
               {ifu_hit, axi_lsu | apb_r_valid, ~axi_lsu, 1'b0}, "read data handshake");
    if (ifu_hit)
      check_r(ifu_r, axi_r, "ifu read data");
    if (axi_lsu)
      check_r(lsu_r, axi_r, "lsu axi read data");
    else if (apb_r_valid)
      check_r(lsu_r, r_exp, "lsu apb read data");
    // Transfers at the coming edge
    if (src_valid & side_rdy & w_exp.last)
      void'(exp_wq.pop_front());
    if ((aw_exp.apb_valid | aw_exp.axi_valid) & aw_exp.hi_ready)
      exp_wq.push_back({aw_exp.hi_win, aw_exp.apb_valid});
  endtask

  // ==============================
  // Stimulus
  // ==============================

  // About half the addresses land in the apb region
  function automatic logic [`BIU_ADDR_W-1:0] rand_addr();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    if (r[63])
      return {apb_base[`BIU_ADDR_W-1:`BIU_REGION_LSB], r[`BIU_REGION_LSB-1:0]};
    return r[`BIU_ADDR_W-1:0];
  endfunction

  function automatic logic [$bits(biu_arb_pkg::ar_req_t)-1:0] rand_req();
    return {rand_addr(), REQ_TAIL_W'($random(seed))};
  endfunction

  function automatic biu_arb_pkg::w_beat_t rand_w();
    biu_arb_pkg::w_beat_t b;
    logic [31:0] r;
    r      = $random(seed);
    b.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
    b.strb = r[`BIU_STRB_W-1:0];
    b.last = r[31];
    return b;
  endfunction

  function automatic biu_arb_pkg::r_beat_t rand_r();
    biu_arb_pkg::r_beat_t b;
    logic [31:0] r;
    r      = $random(seed);
    b.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
    b.id   = r[`BIU_ID_W-1:0];
    b.resp = r[9:8];
    b.last = r[16];
    return b;
  endfunction

  task automatic init_inputs();
    cpurst_b = 1'b0;
    apb_base = 40'h0a_4800_0000;
    {lsu_ar_valid, ifu_ar_valid, vb_aw_valid, stb_aw_valid} = '0;
    {vb_w_valid, stb_w_valid, axi_r_valid, apb_r_valid} = '0;
    {axi_ar_ready, axi_aw_ready, axi_w_ready} = '0;
    {apb_ar_ready, apb_aw_ready, apb_w_ready} = '0;
    {lsu_ar, ifu_ar} = '0;
    {vb_aw, stb_aw} = '0;
    {vb_w, stb_w} = '0;
    {axi_r, apb_r} = '0;
  endtask

  // Sources and responders change every cycle
  task automatic drive_random();
    lsu_ar_valid = 1'($random(seed));
    ifu_ar_valid = 1'($random(seed));
    lsu_ar       = rand_req();
    ifu_ar       = rand_req();
    vb_aw_valid  = 1'($random(seed));
    stb_aw_valid = 1'($random(seed));
    vb_aw        = rand_req();
    stb_aw       = rand_req();
    vb_w_valid   = 1'($random(seed));
    stb_w_valid  = 1'($random(seed));
    vb_w         = rand_w();
    stb_w        = rand_w();
    axi_r_valid  = 1'($random(seed));
    apb_r_valid  = 1'($random(seed));
    axi_r        = rand_r();
    apb_r        = rand_r();
    {axi_ar_ready, axi_aw_ready, axi_w_ready} = 3'($random(seed));
    {apb_ar_ready, apb_aw_ready, apb_w_ready} = 3'($random(seed));
  endtask

  initial
  begin
    arb_clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) arb_clk = ~arb_clk;
  end

  // Compare just before each rising edge
  initial
  begin
    forever
    begin
      @(posedge arb_clk);
      #(SAMPLE_DLY);
      if (cpurst_b)
        compare_cycle();
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Testbench failed");
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $fatal(1, "Watchdog expired");
  end

  initial
  begin
    init_inputs();
    repeat (4) @(posedge arb_clk);
    #(DRIVE_DLY) cpurst_b = 1'b1;
    for (int t = 0; t < RAND_TESTS; t++)
    begin
      repeat (CYCLES_PER_TEST)
      begin
        @(posedge arb_clk);
        #(DRIVE_DLY) drive_random();
      end
    end
    // Drain the queue with last beats only
    @(posedge arb_clk);
    #(DRIVE_DLY);
    {lsu_ar_valid, ifu_ar_valid, axi_r_valid, apb_r_valid} = '0;
    {vb_aw_valid, stb_aw_valid} = '0;
    {vb_w_valid, stb_w_valid} = 2'b11;
    vb_w.last  = 1'b1;
    stb_w.last = 1'b1;
    {apb_w_ready, axi_w_ready, apb_aw_ready, axi_aw_ready} = '1;
    while (exp_wq.size() != 0)
      @(posedge arb_clk);
    // Fill with addresses and no beats
    #(DRIVE_DLY);
    {vb_w_valid, stb_w_valid} = '0;
    vb_aw_valid = 1'b1;
    vb_aw       = rand_req();
    while (exp_wq.size() != `BIU_WQ_DEPTH)
      @(posedge arb_clk);
    repeat (3) @(posedge arb_clk);
    // One last beat frees one entry
    #(DRIVE_DLY) {vb_w_valid, stb_w_valid} = 2'b11;
    while (exp_wq.size() == `BIU_WQ_DEPTH)
      @(posedge arb_clk);
    #(DRIVE_DLY) {vb_w_valid, stb_w_valid} = '0;
    while (exp_wq.size() != `BIU_WQ_DEPTH)
      @(posedge arb_clk);
    repeat (2) @(posedge arb_clk);
    #(DRIVE_DLY);
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: biu_req_arb.f
+incdir+common
+incdir+verification
common/biu_arb_pkg.sv
hw/addr_arbiter.sv
hw/rdata_router.sv
hw/write_order/write_order_queue.sv
hw/biu_req_arb.sv
verification/biu_req_arb_tb.sv

// File: Makefile
# Verilator build and run for the bus request arbiter testbench

VERILATOR ?= verilator
TOP       ?= biu_req_arb_tb
FILELIST  ?= biu_req_arb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh verification/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the exit code
run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@grep -q "Testbench passed" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
